// ==== hdl/sfp_io_pkg.sv ====
// ------------------------------------------------
// SFP+ I/O register package
// Bus widths, register map, MDIO frame constants
// ------------------------------------------------

package sfp_io_pkg;

  localparam int REG_AWIDTH = 14;
  localparam int REG_DWIDTH = 32;

  typedef logic [REG_AWIDTH-1:0] reg_addr_t;
  typedef logic [REG_DWIDTH-1:0] reg_data_t;
  typedef logic [8:0]            mac_status_t;  // CRC, frag, 4x FIFO, pause, lfault, rfault
  typedef logic [15:0]           phy_status_t;

  // Register offsets from REG_BASE
  localparam reg_addr_t OFS_MAC_CTRL_STATUS = 14'h0;
  localparam reg_addr_t OFS_PHY_CTRL_STATUS = 14'h4;
  localparam reg_addr_t OFS_MDIO_CMD        = 14'h10;
  localparam reg_addr_t OFS_MDIO_STATUS     = 14'h14;

  // Readback select codes
  localparam logic [1:0] SEL_MAC_STATUS  = 2'd0;
  localparam logic [1:0] SEL_PHY_STATUS  = 2'd1;
  localparam logic [1:0] SEL_MDIO_CMD    = 2'd2;
  localparam logic [1:0] SEL_MDIO_STATUS = 2'd3;

  // MDIO command and status fields
  localparam int MDIO_RD_BIT   = 26;
  localparam int MDIO_PHY_LSB  = 21;  // 5 bits
  localparam int MDIO_REG_LSB  = 16;  // 5 bits
  localparam int MDIO_BUSY_BIT = 16;

  localparam reg_data_t MAC_CTRL_RESET  = 32'h1;  // Tx enabled
  localparam int        MDC_HALF        = 4;      // bus_clk cycles per MDC half
  localparam int        MDIO_FRAME_BITS = 64;     // 32 preamble + 32 frame

  typedef enum logic [1:0] {IDLE, PREAMBLE, FRAME, DONE} mdio_state_t;

endpackage

// ==== hdl/sfp_reg_decode.sv ====
// ------------------------------------------------
// SFP+ I/O address decoder
// Turns register requests into per-register
// combinational select strobes
// ------------------------------------------------

module sfp_reg_decode #(
  parameter sfp_io_pkg::reg_addr_t REG_BASE = '0
) (
  input  logic                  reg_wr_req_i,
  input  sfp_io_pkg::reg_addr_t reg_wr_addr_i,
  input  logic                  reg_rd_req_i,
  input  sfp_io_pkg::reg_addr_t reg_rd_addr_i,
  output logic                  wr_mac_ctrl_o,
  output logic                  wr_phy_ctrl_o,
  output logic                  wr_mdio_cmd_o,
  output logic                  rd_hit_o,
  output logic [1:0]            rd_sel_o
);
  import sfp_io_pkg::*;

  // Absolute register addresses
  localparam reg_addr_t ADDR_MAC    = reg_addr_t'(REG_BASE + OFS_MAC_CTRL_STATUS);
  localparam reg_addr_t ADDR_PHY    = reg_addr_t'(REG_BASE + OFS_PHY_CTRL_STATUS);
  localparam reg_addr_t ADDR_CMD    = reg_addr_t'(REG_BASE + OFS_MDIO_CMD);
  localparam reg_addr_t ADDR_STATUS = reg_addr_t'(REG_BASE + OFS_MDIO_STATUS);

  // No write strobe for the read-only MDIO status
  assign wr_mac_ctrl_o = reg_wr_req_i && (reg_wr_addr_i == ADDR_MAC);
  assign wr_phy_ctrl_o = reg_wr_req_i && (reg_wr_addr_i == ADDR_PHY);
  assign wr_mdio_cmd_o = reg_wr_req_i && (reg_wr_addr_i == ADDR_CMD);

  always_comb begin
    rd_hit_o = reg_rd_req_i;  // Cleared below on a miss
    rd_sel_o = SEL_MAC_STATUS;
    case (reg_rd_addr_i)
      ADDR_MAC:    rd_sel_o = SEL_MAC_STATUS;
      ADDR_PHY:    rd_sel_o = SEL_PHY_STATUS;
      ADDR_CMD:    rd_sel_o = SEL_MDIO_CMD;
      ADDR_STATUS: rd_sel_o = SEL_MDIO_STATUS;
      default:     rd_hit_o = 1'b0;  // Unmapped address gives no response
    endcase
  end

endmodule

// ==== hdl/sfp_ctrl_status_regs.sv ====
// ------------------------------------------------
// SFP+ control and status registers
// MAC and PHY control words, plus two-flop
// synchronizers for the async status inputs
// ------------------------------------------------

module sfp_ctrl_status_regs (
  input  logic                    bus_clk,
  input  logic                    bus_rst,
  input  logic                    wr_mac_ctrl_i,
  input  logic                    wr_phy_ctrl_i,
  input  sfp_io_pkg::reg_data_t   wr_data_i,
  input  sfp_io_pkg::mac_status_t mac_status_i,
  input  sfp_io_pkg::phy_status_t phy_status_i,
  output sfp_io_pkg::reg_data_t   mac_ctrl_o,
  output sfp_io_pkg::reg_data_t   phy_ctrl_o,
  output sfp_io_pkg::mac_status_t mac_status_sync_o,
  output sfp_io_pkg::phy_status_t phy_status_sync_o
);
  import sfp_io_pkg::*;

  localparam int SYNC_W = $bits(mac_status_t) + $bits(phy_status_t);

  logic [SYNC_W-1:0] sync_meta;  // First stage, may go metastable
  logic [SYNC_W-1:0] sync_q;     // Second stage, safe to use

  // ------------------------------------------------
  // Control words
  // ------------------------------------------------
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      mac_ctrl_o <= MAC_CTRL_RESET;  // Tx enable on
      phy_ctrl_o <= '0;
    end else begin
      if (wr_mac_ctrl_i) begin
        mac_ctrl_o <= wr_data_i;
      end
      if (wr_phy_ctrl_i) begin
        phy_ctrl_o <= wr_data_i;
      end
    end
  end

  // ------------------------------------------------
  // Status synchronizers
  // ------------------------------------------------
  // Both words share one chain, bits are independent
  always_ff @(posedge bus_clk) begin
    sync_meta <= {mac_status_i, phy_status_i};
    sync_q    <= sync_meta;
  end

  assign mac_status_sync_o = sync_q[SYNC_W-1 -: $bits(mac_status_t)];
  assign phy_status_sync_o = sync_q[$bits(phy_status_t)-1:0];

endmodule

// ==== hdl/mdio_master.sv ====
// ------------------------------------------------
// Clause-22 MDIO master
// Runs one read or write frame per command word,
// MDC divided down from bus_clk
// ------------------------------------------------

module mdio_master (
  input  logic                  bus_clk,
  input  logic                  bus_rst,
  input  logic                  cmd_wr_i,
  input  sfp_io_pkg::reg_data_t cmd_data_i,
  input  logic                  mdio_i,
  output logic                  mdc_o,
  output logic                  mdio_o,
  output logic                  mdio_oe_o,
  output logic                  busy_o,
  output sfp_io_pkg::reg_data_t cmd_o,
  output logic [15:0]           rd_data_o
);
  import sfp_io_pkg::*;

  localparam int DIV_W = $clog2(MDC_HALF);
  localparam int CNT_W = $clog2(MDIO_FRAME_BITS);
  localparam logic [DIV_W-1:0] DIV_LAST   = DIV_W'(MDC_HALF - 1);
  localparam logic [CNT_W-1:0] PRE_LAST   = CNT_W'(MDIO_FRAME_BITS / 2 - 1);
  localparam logic [CNT_W-1:0] TA_FIRST   = CNT_W'(MDIO_FRAME_BITS - 18);
  localparam logic [CNT_W-1:0] DATA_FIRST = CNT_W'(MDIO_FRAME_BITS - 16);
  localparam logic [CNT_W-1:0] BIT_LAST   = CNT_W'(MDIO_FRAME_BITS - 1);

  mdio_state_t                state;
  logic [DIV_W-1:0]           div_cnt;   // MDC half-period counter
  logic [CNT_W-1:0]           bit_cnt;   // Bit index in the 64-bit frame
  logic [MDIO_FRAME_BITS-1:0] shift_q;   // Outgoing bits, MSB on the wire
  logic [15:0]                rd_shift;  // Incoming read data
  logic                       active;
  logic                       is_read;
  logic                       mdc_rise;
  logic                       mdc_fall;
  logic [1:0]                 op_bits;
  logic [1:0]                 ta_bits;
  logic [15:0]                wr_bits;

  assign active   = (state == PREAMBLE) || (state == FRAME);
  assign is_read  = cmd_o[MDIO_RD_BIT];
  assign mdc_rise = active && (div_cnt == DIV_LAST) && !mdc_o;
  assign mdc_fall = active && (div_cnt == DIV_LAST) && mdc_o;

  // Frame fields from the incoming command
  assign op_bits = cmd_data_i[MDIO_RD_BIT] ? 2'b10 : 2'b01;
  assign ta_bits = cmd_data_i[MDIO_RD_BIT] ? 2'b11 : 2'b10;     // Read TA is released
  assign wr_bits = cmd_data_i[MDIO_RD_BIT] ? 16'hFFFF : cmd_data_i[15:0];

  // ------------------------------------------------
  // Control FSM
  // ------------------------------------------------
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      state     <= IDLE;
      busy_o    <= 1'b0;
      mdc_o     <= 1'b0;
      div_cnt   <= '0;
      bit_cnt   <= '0;
      cmd_o     <= '0;
      rd_data_o <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (cmd_wr_i) begin  // Commands while busy never get here
            state   <= PREAMBLE;
            busy_o  <= 1'b1;
            cmd_o   <= cmd_data_i;
            mdc_o   <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
          end
        end
        PREAMBLE, FRAME: begin
          div_cnt <= (div_cnt == DIV_LAST) ? '0 : div_cnt + 1'b1;
          if (div_cnt == DIV_LAST) begin
            mdc_o <= ~mdc_o;
          end
          if (mdc_fall) begin  // Bit done, move to next
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == PRE_LAST) begin
              state <= FRAME;
            end else if (bit_cnt == BIT_LAST) begin
              state <= DONE;
            end
          end
        end
        DONE: begin
          if (is_read) begin
            rd_data_o <= rd_shift;  // Valid as busy falls
          end
          busy_o <= 1'b0;
          state  <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // ------------------------------------------------
  // Shift registers
  // ------------------------------------------------
  always_ff @(posedge bus_clk) begin
    if ((state == IDLE) && cmd_wr_i) begin
      shift_q <= {{(MDIO_FRAME_BITS / 2){1'b1}}, 2'b01, op_bits,
                  cmd_data_i[MDIO_PHY_LSB +: 5], cmd_data_i[MDIO_REG_LSB +: 5],
                  ta_bits, wr_bits};
    end else if (mdc_fall) begin
      shift_q <= {shift_q[MDIO_FRAME_BITS-2:0], 1'b1};
    end
    // PHY data must be stable at the MDC rising edge
    if (mdc_rise && is_read && (state == FRAME) && (bit_cnt >= DATA_FIRST)) begin
      rd_shift <= {rd_shift[14:0], mdio_i};
    end
  end

  assign mdio_o    = active ? shift_q[MDIO_FRAME_BITS-1] : 1'b1;  // Idle high
  assign mdio_oe_o = active && !(is_read && (bit_cnt >= TA_FIRST));

  // Caller polls busy, so it must cover the whole frame
  assert property (@(posedge bus_clk) disable iff (bus_rst)
    (state inside {PREAMBLE, FRAME}) |-> busy_o);

endmodule

// ==== hdl/sfp_readback.sv ====
// ------------------------------------------------
// SFP+ register readback
// Picks the read word and returns it with a
// single-cycle response pulse
// ------------------------------------------------

module sfp_readback (
  input  logic                    bus_clk,
  input  logic                    bus_rst,
  input  logic                    rd_hit_i,
  input  logic [1:0]              rd_sel_i,
  input  sfp_io_pkg::mac_status_t mac_status_i,
  input  sfp_io_pkg::phy_status_t phy_status_i,
  input  sfp_io_pkg::reg_data_t   mdio_cmd_i,
  input  logic                    mdio_busy_i,
  input  logic [15:0]             mdio_rd_data_i,
  output logic                    reg_rd_resp_o,
  output sfp_io_pkg::reg_data_t   reg_rd_data_o
);
  import sfp_io_pkg::*;

  reg_data_t rd_word;

  always_comb begin
    rd_word = '0;
    case (rd_sel_i)
      SEL_MAC_STATUS: rd_word = reg_data_t'(mac_status_i);  // Zero extended
      SEL_PHY_STATUS: rd_word = reg_data_t'(phy_status_i);
      SEL_MDIO_CMD:   rd_word = mdio_cmd_i;
      default: begin
        rd_word[MDIO_BUSY_BIT] = mdio_busy_i;
        rd_word[15:0]          = mdio_rd_data_i;
      end
    endcase
  end

  // Response one cycle after each hit
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      reg_rd_resp_o <= 1'b0;
    end else begin
      reg_rd_resp_o <= rd_hit_i;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (rd_hit_i) begin
      reg_rd_data_o <= rd_word;
    end
  end

  // Back-to-back read requests would stretch the pulse
  assert property (@(posedge bus_clk) disable iff (bus_rst)
    reg_rd_resp_o |=> !reg_rd_resp_o);

endmodule

// ==== hdl/sfp_io_regs_top.sv ====
// ------------------------------------------------
// SFP+ I/O register core top level
// Register port, control and status words and
// the MDIO master to the transceiver PHY
// ------------------------------------------------

module sfp_io_regs_top #(
  parameter sfp_io_pkg::reg_addr_t REG_BASE = '0
) (
  input  logic                    bus_clk,
  input  logic                    bus_rst,
  // Register port
  input  logic                    reg_wr_req_i,
  input  sfp_io_pkg::reg_addr_t   reg_wr_addr_i,
  input  sfp_io_pkg::reg_data_t   reg_wr_data_i,
  input  logic                    reg_rd_req_i,
  input  sfp_io_pkg::reg_addr_t   reg_rd_addr_i,
  output logic                    reg_rd_resp_o,
  output sfp_io_pkg::reg_data_t   reg_rd_data_o,
  // MAC and PHY side
  input  sfp_io_pkg::mac_status_t mac_status_i,
  input  sfp_io_pkg::phy_status_t phy_status_i,
  output sfp_io_pkg::reg_data_t   mac_ctrl_o,
  output sfp_io_pkg::reg_data_t   phy_ctrl_o,
  // MDIO pins
  output logic                    mdc_o,
  output logic                    mdio_o,
  output logic                    mdio_oe_o,
  input  logic                    mdio_i
);
  import sfp_io_pkg::*;

  logic        wr_mac_ctrl, wr_phy_ctrl, wr_mdio_cmd;
  logic        rd_hit;
  logic [1:0]  rd_sel;
  mac_status_t mac_status_sync;
  phy_status_t phy_status_sync;
  reg_data_t   mdio_cmd;
  logic        mdio_busy;
  logic [15:0] mdio_rd_data;

  sfp_reg_decode #(.REG_BASE(REG_BASE)) decode_i (
    .reg_wr_req_i, .reg_wr_addr_i, .reg_rd_req_i, .reg_rd_addr_i,
    .wr_mac_ctrl_o(wr_mac_ctrl), .wr_phy_ctrl_o(wr_phy_ctrl),
    .wr_mdio_cmd_o(wr_mdio_cmd), .rd_hit_o(rd_hit), .rd_sel_o(rd_sel)
  );

  sfp_ctrl_status_regs csr_i (
    .bus_clk, .bus_rst, .wr_mac_ctrl_i(wr_mac_ctrl), .wr_phy_ctrl_i(wr_phy_ctrl),
    .wr_data_i(reg_wr_data_i), .mac_status_i, .phy_status_i, .mac_ctrl_o, .phy_ctrl_o,
    .mac_status_sync_o(mac_status_sync), .phy_status_sync_o(phy_status_sync)
  );

  mdio_master mdio_master_i (
    .bus_clk, .bus_rst, .cmd_wr_i(wr_mdio_cmd), .cmd_data_i(reg_wr_data_i), .mdio_i,
    .mdc_o, .mdio_o, .mdio_oe_o, .busy_o(mdio_busy), .cmd_o(mdio_cmd),
    .rd_data_o(mdio_rd_data)
  );

  sfp_readback readback_i (
    .bus_clk, .bus_rst, .rd_hit_i(rd_hit), .rd_sel_i(rd_sel),
    .mac_status_i(mac_status_sync), .phy_status_i(phy_status_sync),
    .mdio_cmd_i(mdio_cmd), .mdio_busy_i(mdio_busy), .mdio_rd_data_i(mdio_rd_data),
    .reg_rd_resp_o, .reg_rd_data_o
  );

endmodule

// ==== verification/mdio_phy_model.sv ====
// --------------------------------------------------
// Behavioral Clause-22 MDIO PHY
// 32 x 16-bit register file, answers at one
// PHY address, reads driven on MDC falling edges
// --------------------------------------------------

module mdio_phy_model #(
  parameter logic [4:0] PHY_ADDR = 5'd4
) (
  input  logic mdc_i,
  input  logic mdio_i,     // Master data out
  input  logic mdio_oe_i,  // Master drives the line
  output logic mdio_o      // PHY side of the line
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [15:0] regs [32];
  logic [31:0] frame     = '0;  // Start bit lands in bit 31 at the end
  int          cnt       = 0;   // Frame bits seen, 0 while hunting
  logic        rd_active = 1'b0;
  logic [15:0] rd_word   = '0;
  logic        drive_en  = 1'b0;
  logic        drive_bit = 1'b1;
  logic        line;

  assign mdio_o = drive_en ? drive_bit : 1'b1;  // Pull-up when nobody drives
  assign line   = mdio_oe_i ? mdio_i : mdio_o;

  initial begin
    for (int i = 0; i < 32; i++) begin
      regs[i] = 16'hC000 + 16'(i);  // Untouched register pattern
    end
  end

  // Sample the line on MDC rising edges
  always @(posedge mdc_i) begin
    if ((cnt != 0) || (line == 1'b0)) begin  // First zero after preamble is the start
      frame = {frame[30:0], line};
      cnt   = cnt + 1;
    end
    if (cnt == 16) begin  // Header and turnaround seen
      rd_active = (frame[13:12] == 2'b10) && (frame[11:7] == PHY_ADDR);
      rd_word   = regs[frame[6:2]];
    end
    if (cnt == 32) begin
      if ((frame[29:28] == 2'b01) && (frame[27:23] == PHY_ADDR)) begin
        regs[frame[22:18]] = frame[15:0];  // Write frame complete
      end
      cnt       = 0;
      rd_active = 1'b0;
    end
  end

  // Read data goes out MSB first, ahead of the master's sampling edge
  always @(negedge mdc_i) begin
    if (rd_active && (cnt >= 16) && (cnt < 32)) begin
      drive_en  <= 1'b1;
      drive_bit <= rd_word[31 - cnt];
    end else begin
      drive_en  <= 1'b0;
    end
  end

endmodule

// ==== verification/sfp_io_tb.sv ====
// --------------------------------------------------
// SFP+ I/O register core testbench
// Replays register operations from a vector file
// against the DUT and a behavioral MDIO PHY
// --------------------------------------------------

module sfp_io_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import sfp_io_pkg::*;

  localparam string VEC_FILE    = "verification/reg_input.txt";
  localparam int    RST_CYCLES  = 4;
  localparam int    LINE_CYCLES = 700;  // Budget per vector line

  logic        bus_clk;
  logic        bus_rst;
  logic        wr_req;
  logic        rd_req;
  reg_addr_t   wr_addr;
  reg_addr_t   rd_addr;
  reg_data_t   wr_data;
  logic        rd_resp;
  reg_data_t   rd_data;
  mac_status_t mac_status;
  phy_status_t phy_status;
  reg_data_t   mac_ctrl;
  reg_data_t   phy_ctrl;
  logic        mdc;
  logic        mdio_out;
  logic        mdio_oe;
  logic        mdio_in;

  byte         op_q[$];
  reg_addr_t   addr_q[$];
  reg_data_t   data_q[$];
  reg_data_t   exp_q[$];
  reg_data_t   exp_mac      = 32'h1;  // Tx enable after reset
  reg_data_t   exp_phy      = '0;
  logic [31:0] rng_state    = 32'd83;
  int          lines_read   = 0;
  int          checks       = 0;
  int          value_errors = 0;
  int          other_errors = 0;
  int          cycle_count  = 0;
  int          cycle_limit  = 0;  // Zero until the vectors are loaded

  sfp_io_regs_top #(.REG_BASE(14'h0)) dut_i (
    .bus_clk, .bus_rst,
    .reg_wr_req_i(wr_req), .reg_wr_addr_i(wr_addr), .reg_wr_data_i(wr_data),
    .reg_rd_req_i(rd_req), .reg_rd_addr_i(rd_addr),
    .reg_rd_resp_o(rd_resp), .reg_rd_data_o(rd_data),
    .mac_status_i(mac_status), .phy_status_i(phy_status),
    .mac_ctrl_o(mac_ctrl), .phy_ctrl_o(phy_ctrl),
    .mdc_o(mdc), .mdio_o(mdio_out), .mdio_oe_o(mdio_oe), .mdio_i(mdio_in)
  );

  mdio_phy_model #(.PHY_ADDR(5'd4)) phy_i (
    .mdc_i(mdc), .mdio_i(mdio_out), .mdio_oe_i(mdio_oe), .mdio_o(mdio_in)
  );

  initial begin
    bus_clk = 1'b0;
    forever #5 bus_clk = ~bus_clk;
  end

  // Run watchdog
  always @(posedge bus_clk) begin
    cycle_count <= cycle_count + 1;
    if ((cycle_limit != 0) && (cycle_count >= cycle_limit)) begin
      $display("ERROR: timeout, no progress after %0d cycles", cycle_count);
      other_errors++;
      finish_run();
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // Register map with the DUT at base 0
  function automatic bit is_mapped(input reg_addr_t addr);
    return (addr == OFS_MAC_CTRL_STATUS) || (addr == OFS_PHY_CTRL_STATUS) ||
           (addr == OFS_MDIO_CMD) || (addr == OFS_MDIO_STATUS);
  endfunction

  // ------------------------------------------------
  // Bus tasks
  // ------------------------------------------------
  // Requests low, address and data lines get noise
  task automatic drive_idle();
    rng_state = xorshift32(rng_state);
    wr_req  <= 1'b0;
    rd_req  <= 1'b0;
    wr_addr <= rng_state[13:0];
    rd_addr <= rng_state[31:18];
    wr_data <= rng_state;
  endtask

  task automatic check_word(input string name, input reg_data_t got, input reg_data_t expv);
    checks++;
    if (got !== expv) begin
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, expv);
      value_errors++;
    end
  endtask

  task automatic bus_write(input reg_addr_t addr, input reg_data_t data);
    @(posedge bus_clk);
    wr_req  <= 1'b1;
    rd_req  <= 1'b0;
    wr_addr <= addr;
    wr_data <= data;
    if (addr == OFS_MAC_CTRL_STATUS) begin
      exp_mac = data;
    end else if (addr == OFS_PHY_CTRL_STATUS) begin
      exp_phy = data;
    end
    @(posedge bus_clk);
    drive_idle();
    @(negedge bus_clk);  // New control word visible one cycle on
    check_word("mac_ctrl_o", mac_ctrl, exp_mac);
    check_word("phy_ctrl_o", phy_ctrl, exp_phy);
  endtask

  // Watches 3 cycles, seen[0] is the cycle right after the request
  task automatic bus_read(input reg_addr_t addr, output reg_data_t data,
                          output logic [2:0] seen);
    data = '0;
    @(posedge bus_clk);
    rd_req  <= 1'b1;
    wr_req  <= 1'b0;
    rd_addr <= addr;
    for (int i = 0; i < 3; i++) begin
      @(posedge bus_clk);
      drive_idle();
      @(negedge bus_clk);
      seen[i] = rd_resp;
      if (rd_resp) begin
        data = rd_data;
      end
    end
  endtask

  task automatic check_read(input reg_addr_t addr, input reg_data_t expv);
    reg_data_t  got;
    logic [2:0] seen;
    bus_read(addr, got, seen);
    checks++;
    if (is_mapped(addr)) begin
      if (seen != 3'b001) begin
        $display("ERROR: read of 0x%h did not give one pulse one cycle later (%b)",
                 addr, seen);
        other_errors++;
      end else begin
        check_word("reg_rd_data_o", got, expv);
      end
    end else if (seen != 3'b000) begin
      $display("ERROR: read of unmapped address 0x%h gave a response", addr);
      other_errors++;
    end
  endtask

  // MAC status in bits 24..16, PHY status in 15..0
  task automatic set_status(input reg_data_t data);
    @(posedge bus_clk);
    mac_status <= data[24:16];
    phy_status <= data[15:0];
    drive_idle();
    repeat (3) begin  // Past the synchronizer
      @(posedge bus_clk);
      drive_idle();
    end
  endtask

  task automatic poll_mdio(input reg_data_t expv);
    reg_data_t  word;
    logic [2:0] seen;
    do begin
      bus_read(OFS_MDIO_STATUS, word, seen);
      if (seen != 3'b001) begin
        $display("ERROR: MDIO status poll got no single response pulse (%b)", seen);
        other_errors++;
        word = '0;
      end
    end while (word[MDIO_BUSY_BIT]);
    check_word("reg_rd_data_o", word, expv);
  endtask

  task automatic run_vector(input byte op, input reg_addr_t addr, input reg_data_t data,
                            input reg_data_t expv);
    case (op)
      "W": bus_write(addr, data);
      "R": check_read(addr, expv);
      "S": set_status(data);
      "P": poll_mdio(expv);
      default: begin
        $display("ERROR: unknown operation code '%c' in the vector file", op);
        other_errors++;
      end
    endcase
  endtask

  // ------------------------------------------------
  // Vector file and run control
  // ------------------------------------------------
  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    byte         op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] expv;
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0) begin
      $display("ERROR: cannot open the vector file %s", VEC_FILE);
      other_errors++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      lines_read++;
      if (line.getc(0) != "#") begin  // Comment lines skipped
        n = $sscanf(line, "%c %h %h %h", op, addr, data, expv);
        if (n == 4) begin
          op_q.push_back(op);
          addr_q.push_back(addr[13:0]);
          data_q.push_back(data);
          exp_q.push_back(expv);
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic finish_run();
    $display("Summary: %0d checks, %0d value errors, %0d other errors",
             checks, value_errors, other_errors);
    if ((value_errors == 0) && (other_errors == 0)) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  endtask

  initial begin
    bus_rst    = 1'b1;
    wr_req     = 1'b0;
    rd_req     = 1'b0;
    wr_addr    = '0;
    rd_addr    = '0;
    wr_data    = '0;
    mac_status = '0;
    phy_status = '0;
    load_vectors();
    cycle_limit = LINE_CYCLES * lines_read + 100;
    repeat (RST_CYCLES) @(posedge bus_clk);
    bus_rst <= 1'b0;
    @(negedge bus_clk);
    check_word("mac_ctrl_o", mac_ctrl, 32'h1);
    check_word("phy_ctrl_o", phy_ctrl, 32'h0);
    check_word("reg_rd_resp_o", 32'(rd_resp), 32'h0);
    check_word("mdc_o", 32'(mdc), 32'h0);
    check_word("mdio_oe_o", 32'(mdio_oe), 32'h0);
    check_word("mdio_o", 32'(mdio_out), 32'h1);  // Idle high
    foreach (op_q[i]) begin
      run_vector(op_q[i], addr_q[i], data_q[i], exp_q[i]);
    end
    repeat (2) @(posedge bus_clk);
    finish_run();
  end

endmodule

// ==== compile.f ====
hdl/sfp_io_pkg.sv
hdl/sfp_reg_decode.sv
hdl/sfp_ctrl_status_regs.sv
hdl/mdio_master.sv
hdl/sfp_readback.sv
hdl/sfp_io_regs_top.sv
verification/mdio_phy_model.sv
verification/sfp_io_tb.sv

// ==== Makefile ====
TOP := sfp_io_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build output"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -f compile.f \
	  --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir

// ==== verification/reg_input.txt ====
# op addr data expected (hex), op W write, R read and compare, S set status, P poll MDIO
# S data holds MAC status in bits 24..16 and PHY status in 15..0, P checks the idle status word
R 0000 00000000 00000000
R 0004 00000000 00000000
R 0014 00000000 00000000
W 0000 0000000f 00000000
W 0004 a5a5c3c3 00000000
S 0000 01ab1234 00000000
R 0000 00000000 000001ab
R 0004 00000000 00001234
S 0000 00150fed 00000000
R 0000 00000000 00000015
R 0004 00000000 00000fed
R 0008 00000000 00000000
R 3ffc 00000000 00000000
W 0008 deadbeef 00000000
W 0014 12345678 00000000
W 2000 ffffffff 00000000
W 0010 00851234 00000000
R 0010 00000000 00851234
P 0014 00000000 00000000
W 0010 04850000 00000000
P 0014 00000000 00001234
W 0010 04850000 00000000
W 0010 00895555 00000000
R 0010 00000000 04850000
P 0014 00000000 00001234
W 0010 04890000 00000000
P 0014 00000000 0000c009
R 0000 00000000 00000015
